// File: files.f
+incdir+hdl
hdl/soc_pkg.sv
hdl/soc_reset_ctrl.sv
hdl/pi1_router.sv
hdl/dev_table.sv
hdl/gpio_dev.sv
hdl/int_ctrl.sv
hdl/soc_top.sv
verif/soc_assert.sv
verif/soc_tb.sv

// File: verif/soc_tb.sv
// Testbench for the peripheral fabric. Drives the PI1 master port and the
// GPIO and interrupt pins of soc_top, and checks reset, bus and interrupt behavior.
`timescale 1ns/1ns
`include "soc_config.svh"

module soc_tb import soc_pkg::*; ();

	localparam int wait_limit = 50;
	localparam logic [`ADDR_BITSZ-1:0] unmapped_addr = 30'h100;
	localparam logic [6:0] exp_id [`DEV_COUNT] = '{
		`DEVTBL_ID, `GPIO_ID, `INTCTRL_ID, `INVALID_ID
	};
	localparam int exp_mapsz [`DEV_COUNT] = '{
		`SLOT_WORDS, `SLOT_WORDS, `SLOT_WORDS, `INVALID_MAPSZ
	};
	localparam logic exp_useintr [`DEV_COUNT] = '{
		`DEVTBL_USEINTR, `GPIO_USEINTR, `INTCTRL_USEINTR, `INVALID_USEINTR
	};

	logic                   clk100mhz;
	logic                   rst_p;
	pi1_op_t                op_i;
	logic [`ADDR_BITSZ-1:0] addr_i;
	logic [`ARCH_BITSZ-1:0] data_i;
	logic [`SEL_BITSZ-1:0]  sel_i;
	logic [`GPIO_COUNT-1:0] gp_i;
	logic                   intrdy_i;
	logic [`ARCH_BITSZ-1:0] data_o;
	logic                   rdy_o;
	logic [`GPIO_COUNT-1:1] gp_o;
	logic                   intrqst_o;
	logic                   sys_rst_o;
	int                     mismatches = 0;
	int                     timeouts = 0;

	soc_top dut0 (
		.clk100mhz (clk100mhz),
		.rst_p     (rst_p),
		.op_i      (op_i),
		.addr_i    (addr_i),
		.data_i    (data_i),
		.sel_i     (sel_i),
		.gp_i      (gp_i),
		.intrdy_i  (intrdy_i),
		.data_o    (data_o),
		.rdy_o     (rdy_o),
		.gp_o      (gp_o),
		.intrqst_o (intrqst_o),
		.sys_rst_o (sys_rst_o)
	);

	bind soc_top soc_assert assert0 (
		.clk100mhz (clk100mhz),
		.rst_p     (rst_p),
		.op_i      (op_i),
		.rdy_i     (rdy_o),
		.intrqst_i (intrqst_o),
		.intrdy_i  (intrdy_i),
		.sys_rst_i (sys_rst_o)
	);

	initial begin
		clk100mhz = 1'b0;
		forever #5 clk100mhz = ~clk100mhz;
	end

	// ********************
	// Helpers.
	task automatic next_cycle();
		@(posedge clk100mhz);
		#1;
	endtask

	task automatic check_value(input string name, input logic [`ARCH_BITSZ-1:0] got,
			input logic [`ARCH_BITSZ-1:0] exp);
		assert (got === exp) else begin
			$display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
			mismatches++;
		end
	endtask

	// Called 1 ns after a rising edge. Holds op until the edge that samples rdy_o.
	task automatic transfer(input pi1_op_t op, input logic [`ADDR_BITSZ-1:0] addr,
			input logic [`ARCH_BITSZ-1:0] wdata, output logic [`ARCH_BITSZ-1:0] rdata);
		int cycles;
		op_i   = op;
		addr_i = addr;
		data_i = wdata;
		sel_i  = '1;
		cycles = 0;
		@(negedge clk100mhz);
		while (!rdy_o && cycles < wait_limit) begin
			@(negedge clk100mhz);
			cycles++;
		end
		if (!rdy_o) begin
			$display("ERROR: no rdy_o for the transfer at address %h", addr);
			timeouts++;
		end
		rdata = data_o;
		next_cycle();
		op_i = NONE;
	endtask

	task automatic read_word(input logic [`ADDR_BITSZ-1:0] addr,
			output logic [`ARCH_BITSZ-1:0] rdata);
		transfer(READ, addr, '0, rdata);
	endtask

	task automatic write_word(input logic [`ADDR_BITSZ-1:0] addr,
			input logic [`ARCH_BITSZ-1:0] wdata);
		logic [`ARCH_BITSZ-1:0] unused;
		transfer(WRITE, addr, wdata, unused);
	endtask

	// Counts cycles until sys_rst_o falls; outputs must stay quiet meanwhile.
	task automatic measure_hold_off(input int expected);
		int cycles;
		cycles = 0;
		while (sys_rst_o && cycles < wait_limit) begin
			next_cycle();
			cycles++;
			if (sys_rst_o) begin
				check_value("rdy_o", rdy_o, 0);
				check_value("intrqst_o", intrqst_o, 0);
				check_value("gp_o", gp_o, 0);
			end
		end
		if (sys_rst_o) begin
			$display("ERROR: sys_rst_o never fell after the reset");
			timeouts++;
		end
		check_value("hold-off cycles", cycles, expected);
	endtask

	// Destination side of the four-phase exchange up to the fall of intrqst_o.
	// The caller drops intrdy_i afterwards.
	task automatic acknowledge_intr();
		int cycles;
		cycles = 0;
		@(negedge clk100mhz);
		while (!intrqst_o && cycles < wait_limit) begin
			@(negedge clk100mhz);
			cycles++;
		end
		if (!intrqst_o) begin
			$display("ERROR: intrqst_o was never raised");
			timeouts++;
		end
		next_cycle();
		intrdy_i = 1'b1;
		cycles = 0;
		@(negedge clk100mhz);
		while (intrqst_o && cycles < wait_limit) begin
			@(negedge clk100mhz);
			cycles++;
		end
		if (intrqst_o) begin
			$display("ERROR: intrqst_o stayed high after intrdy_i was raised");
			timeouts++;
		end
		next_cycle();
	endtask

	task automatic pulse_reset();
		rst_p = 1'b1;
		repeat (3) next_cycle();
		rst_p = 1'b0;
	endtask

	// ********************
	// Stimulus.
	initial begin
		int                     seed;
		int                     polls;
		logic [`ARCH_BITSZ-1:0] gp_val;
		logic [`ARCH_BITSZ-1:0] rd;
		logic [`GPIO_COUNT-1:0] gp_in;
		logic [7:0]             out_val;
		devtbl_entry_u          entry;

		seed     = 3;
		out_val  = 8'hA5;
		rst_p    = 1'b1;
		op_i     = NONE;
		addr_i   = '0;
		data_i   = '0;
		sel_i    = '0;
		gp_i     = '0;
		intrdy_i = 1'b0;

		repeat (3) next_cycle();
		rst_p = 1'b0;
		measure_hold_off(15);

		for (int n = 0; n < `DEV_COUNT; n++) begin
			read_word(`DEVTBL_BASE + 30'(n + 1), entry.raw);
			check_value($sformatf("entry %0d id", n), entry.f.id, exp_id[n]);
			check_value($sformatf("entry %0d mapsz", n), entry.f.mapsz, exp_mapsz[n]);
			check_value($sformatf("entry %0d useintr", n), entry.f.useintr, exp_useintr[n]);
		end

		write_word(`GPIO_BASE + 30'd1, 32'(out_val));
		check_value("gp_o", gp_o, out_val[7:1]);
		read_word(`GPIO_BASE + 30'd1, rd);
		check_value("gpio word 1", rd, {out_val[7:1], 1'b0});

		gp_val = $random(seed);
		gp_in  = gp_val[`GPIO_COUNT-1:0];
		if (gp_in == '0) begin
			gp_in = 8'h01; // Zero would not count as a change.
		end
		gp_i  = gp_in;
		polls = 0;
		read_word(`GPIO_BASE, rd);
		while ((rd != 32'(gp_in)) && polls < wait_limit) begin
			read_word(`GPIO_BASE, rd);
			polls++;
		end
		check_value("gpio word 0", rd, 32'(gp_in));

		acknowledge_intr();
		read_word(`INTCTRL_BASE, rd);
		check_value("int_ctrl source", rd, `INT_SRC_GPIO);

		// The invalid access arrives while intrdy_i is still high from the GPIO interrupt.
		read_word(unmapped_addr, rd);
		check_value("invalid read data", rd, 0);
		next_cycle();
		intrdy_i = 1'b0;
		acknowledge_intr();
		intrdy_i = 1'b0;
		read_word(`INTCTRL_BASE, rd);
		check_value("int_ctrl source", rd, `INT_SRC_INVALID);

		// The command stays set for the first reset cycle, so the hold-off is 1 + 15.
		write_word(`DEVTBL_BASE, 32'h2);
		check_value("sys_rst_o after warm reset", sys_rst_o, 1);
		measure_hold_off(16);

		write_word(`DEVTBL_BASE, 32'h1);
		for (int i = 0; i < 32; i++) begin
			next_cycle();
			check_value("sys_rst_o after power-off", sys_rst_o, 1);
		end
		pulse_reset();
		measure_hold_off(15);

		$display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
			mismatches, timeouts, dut0.assert0.fail_cnt);
		if (mismatches + timeouts + dut0.assert0.fail_cnt == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: verif/soc_assert.sv
// Bus, interrupt and reset protocol checks on the fabric top.
// Bound to soc_top by the testbench.
`timescale 1ns/1ns

module soc_assert import soc_pkg::*; (
	input logic    clk100mhz,
	input logic    rst_p,
	input pi1_op_t op_i,
	input logic    rdy_i,
	input logic    intrqst_i,
	input logic    intrdy_i,
	input logic    sys_rst_i
);

	int fail_cnt = 0;

	// ********************
	// PI1 handshake.
	assert property (@(posedge clk100mhz) disable iff (rst_p) rdy_i |-> (op_i != NONE))
	else begin
		$error("rdy_o is high with no transfer on op_i");
		fail_cnt++;
	end

	// ********************
	// Four-phase interrupt request toward the destination.
	assert property (@(posedge clk100mhz) disable iff (sys_rst_i)
			(intrqst_i && !intrdy_i) |=> intrqst_i)
	else begin
		$error("intrqst_o dropped before intrdy_i was seen");
		fail_cnt++;
	end

	assert property (@(posedge clk100mhz) disable iff (sys_rst_i)
			(!intrqst_i && intrdy_i) |=> !intrqst_i)
	else begin
		$error("intrqst_o rose while intrdy_i was still high");
		fail_cnt++;
	end

	// ********************
	// The board reset reaches the system and outlasts rst_p.
	assert property (@(posedge clk100mhz) rst_p |=> sys_rst_i)
	else begin
		$error("sys_rst_o was low right after rst_p was high");
		fail_cnt++;
	end

endmodule

// File: hdl/soc_top.sv
// Peripheral fabric top. One PI1 master port drives the device table, GPIO
// and interrupt controller through the router, all on clk100mhz.
`timescale 1ns/1ns
`include "soc_config.svh"

module soc_top import soc_pkg::*; (
	input  logic                   clk100mhz,
	input  logic                   rst_p,
	input  pi1_op_t                op_i,
	input  logic [`ADDR_BITSZ-1:0] addr_i,
	input  logic [`ARCH_BITSZ-1:0] data_i,
	input  logic [`SEL_BITSZ-1:0]  sel_i,
	input  logic [`GPIO_COUNT-1:0] gp_i,
	input  logic                   intrdy_i,
	output logic [`ARCH_BITSZ-1:0] data_o,
	output logic                   rdy_o,
	output logic [`GPIO_COUNT-1:1] gp_o,
	output logic                   intrqst_o,
	output logic                   sys_rst_o
);

	logic                        warm_rst_w;
	logic                        pwroff_w;
	pi1_op_t                     s_op_w [`DEV_COUNT-1];
	logic [`SLOT_ADDR_BITSZ-1:0] s_addr_w;
	logic [`ARCH_BITSZ-1:0]      s_wdata_w;
	logic [`SEL_BITSZ-1:0]       s_sel_w;
	logic [`ARCH_BITSZ-1:0]      s_rdata_w [`DEV_COUNT-1];
	logic [`DEV_COUNT-2:0]       s_rdy_w;
	logic [`INT_SRC_COUNT-1:0]   src_req_w;
	logic [`INT_SRC_COUNT-1:0]   src_ack_w;

	soc_reset_ctrl rst_ctrl0 (
		.clk100mhz  (clk100mhz),
		.rst_p      (rst_p),
		.warm_rst_i (warm_rst_w),
		.pwroff_i   (pwroff_w),
		.sys_rst_o  (sys_rst_o)
	);

	pi1_router router0 (
		.clk100mhz     (clk100mhz),
		.sys_rst_i     (sys_rst_o),
		.m_op_i        (op_i),
		.m_addr_i      (addr_i),
		.m_data_i      (data_i),
		.m_sel_i       (sel_i),
		.m_data_o      (data_o),
		.m_rdy_o       (rdy_o),
		.s_op_o        (s_op_w),
		.s_addr_o      (s_addr_w),
		.s_data_o      (s_wdata_w),
		.s_sel_o       (s_sel_w),
		.s_data_i      (s_rdata_w),
		.s_rdy_i       (s_rdy_w),
		.errintr_o     (src_req_w[`INT_SRC_INVALID]),
		.errintr_ack_i (src_ack_w[`INT_SRC_INVALID])
	);

	// ********************
	// Device slots.
	dev_table devtbl0 (
		.clk100mhz  (clk100mhz),
		.sys_rst_i  (sys_rst_o),
		.op_i       (s_op_w[`SLOT_DEVTBL]),
		.addr_i     (s_addr_w),
		.data_i     (s_wdata_w),
		.sel_i      (s_sel_w),
		.data_o     (s_rdata_w[`SLOT_DEVTBL]),
		.rdy_o      (s_rdy_w[`SLOT_DEVTBL]),
		.warm_rst_o (warm_rst_w),
		.pwroff_o   (pwroff_w)
	);

	gpio_dev gpio0 (
		.clk100mhz  (clk100mhz),
		.sys_rst_i  (sys_rst_o),
		.op_i       (s_op_w[`SLOT_GPIO]),
		.addr_i     (s_addr_w),
		.data_i     (s_wdata_w),
		.sel_i      (s_sel_w),
		.gp_i       (gp_i),
		.intr_ack_i (src_ack_w[`INT_SRC_GPIO]),
		.data_o     (s_rdata_w[`SLOT_GPIO]),
		.rdy_o      (s_rdy_w[`SLOT_GPIO]),
		.gp_o       (gp_o),
		.intr_req_o (src_req_w[`INT_SRC_GPIO])
	);

	int_ctrl intctrl0 (
		.clk100mhz (clk100mhz),
		.sys_rst_i (sys_rst_o),
		.op_i      (s_op_w[`SLOT_INTCTRL]),
		.addr_i    (s_addr_w),
		.data_i    (s_wdata_w),
		.sel_i     (s_sel_w),
		.src_req_i (src_req_w),
		.intrdy_i  (intrdy_i),
		.data_o    (s_rdata_w[`SLOT_INTCTRL]),
		.rdy_o     (s_rdy_w[`SLOT_INTCTRL]),
		.src_ack_o (src_ack_w),
		.intrqst_o (intrqst_o)
	);

endmodule

// File: hdl/int_ctrl.sv
// Interrupt controller. Takes the lowest pending source, passes it to the one
// destination over four-phase req/ack, and reports the source index on word 0.
`timescale 1ns/1ns
`include "soc_config.svh"

module int_ctrl import soc_pkg::*; (
	input  logic                        clk100mhz,
	input  logic                        sys_rst_i,
	input  pi1_op_t                     op_i,
	input  logic [`SLOT_ADDR_BITSZ-1:0] addr_i,
	input  logic [`ARCH_BITSZ-1:0]      data_i,
	input  logic [`SEL_BITSZ-1:0]       sel_i,
	input  logic [`INT_SRC_COUNT-1:0]   src_req_i,
	input  logic                        intrdy_i,
	output logic [`ARCH_BITSZ-1:0]      data_o,
	output logic                        rdy_o,
	output logic [`INT_SRC_COUNT-1:0]   src_ack_o,
	output logic                        intrqst_o
);

	localparam int src_idx_bitsz = $clog2(`INT_SRC_COUNT);

	logic                      req_w;
	logic [src_idx_bitsz-1:0]  grant_w;
	logic                      grant_vld_w;
	logic [`INT_SRC_COUNT-1:0] src_ack_q;
	logic [src_idx_bitsz-1:0]  last_src_q;
	logic                      intrqst_q;
	logic                      rdy_q;
	logic [`ARCH_BITSZ-1:0]    data_q;

	// Registers here are read-only, so writes complete without effect.
	assign req_w = (op_i != NONE) && !rdy_q;

	always_comb begin
		grant_w     = '0;
		grant_vld_w = 1'b0;
		for (int i = `INT_SRC_COUNT-1; i >= 0; i--) begin
			if (src_req_i[i] && !src_ack_q[i]) begin
				grant_w     = src_idx_bitsz'(i); // Lowest index wins.
				grant_vld_w = 1'b1;
			end
		end
	end

	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i) begin
			src_ack_q  <= '0;
			last_src_q <= '0;
			intrqst_q  <= 1'b0;
		end else begin
			for (int i = 0; i < `INT_SRC_COUNT; i++) begin
				if (!src_req_i[i]) begin
					src_ack_q[i] <= 1'b0;
				end
			end
			if (intrqst_q && intrdy_i) begin
				intrqst_q <= 1'b0;
			end else if (!intrqst_q && !intrdy_i && grant_vld_w) begin
				src_ack_q[grant_w] <= 1'b1;
				last_src_q         <= grant_w;
				intrqst_q          <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i) begin
			rdy_q <= 1'b0;
		end else begin
			rdy_q <= req_w;
		end
	end

	always_ff @(posedge clk100mhz) begin
		if (req_w) begin
			data_q <= (addr_i == '0) ?
				{{(`ARCH_BITSZ-src_idx_bitsz){1'b0}}, last_src_q} : '0;
		end
	end

	assign data_o    = data_q;
	assign rdy_o     = rdy_q;
	assign src_ack_o = src_ack_q;
	assign intrqst_o = intrqst_q;

endmodule

// File: hdl/gpio_dev.sv
// GPIO slot. Word 0 reads the synchronized inputs, word 1 holds the outputs;
// an input change since the last read of word 0 requests an interrupt.
`timescale 1ns/1ns
`include "soc_config.svh"

module gpio_dev import soc_pkg::*; (
	input  logic                        clk100mhz,
	input  logic                        sys_rst_i,
	input  pi1_op_t                     op_i,
	input  logic [`SLOT_ADDR_BITSZ-1:0] addr_i,
	input  logic [`ARCH_BITSZ-1:0]      data_i,
	input  logic [`SEL_BITSZ-1:0]       sel_i,
	input  logic [`GPIO_COUNT-1:0]      gp_i,
	input  logic                        intr_ack_i,
	output logic [`ARCH_BITSZ-1:0]      data_o,
	output logic                        rdy_o,
	output logic [`GPIO_COUNT-1:1]      gp_o,
	output logic                        intr_req_o
);

	logic                   req_w;
	logic                   rd_w;
	logic                   wr_w;
	logic [`ARCH_BITSZ-1:0] rd_data_w;
	logic [`GPIO_COUNT-1:0] gp_s1;
	logic [`GPIO_COUNT-1:0] gp_s2;
	logic [`GPIO_COUNT-1:0] last_rd_q;
	logic [`GPIO_COUNT-1:1] out_q;
	logic                   rdy_q;
	logic                   intr_q;
	logic [`ARCH_BITSZ-1:0] data_q;

	assign req_w = (op_i != NONE) && !rdy_q;
	assign rd_w  = req_w && ((op_i == READ) || (op_i == SWAP));
	assign wr_w  = req_w && ((op_i == WRITE) || (op_i == SWAP));

	always_comb begin
		case (addr_i)
			'd0:     rd_data_w = {{(`ARCH_BITSZ-`GPIO_COUNT){1'b0}}, gp_s2};
			'd1:     rd_data_w = {{(`ARCH_BITSZ-`GPIO_COUNT){1'b0}}, out_q, 1'b0};
			default: rd_data_w = '0;
		endcase
	end

	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i) begin
			gp_s1     <= '0;
			gp_s2     <= '0;
			last_rd_q <= '0;
			out_q     <= '0;
			rdy_q     <= 1'b0;
		end else begin
			gp_s1 <= gp_i;
			gp_s2 <= gp_s1;
			rdy_q <= req_w;
			if (rd_w && (addr_i == '0)) begin
				last_rd_q <= gp_s2; // Software has now seen this input value.
			end
			if (wr_w && (addr_i == 'd1) && sel_i[0]) begin
				out_q <= data_i[`GPIO_COUNT-1:1];
			end
		end
	end

	// Four-phase request, raised again after ack falls while the change is unread.
	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i) begin
			intr_q <= 1'b0;
		end else if (intr_ack_i) begin
			intr_q <= 1'b0;
		end else if (gp_s2 != last_rd_q) begin
			intr_q <= 1'b1;
		end
	end

	always_ff @(posedge clk100mhz) begin
		if (req_w) begin
			data_q <= rd_data_w;
		end
	end

	assign data_o     = data_q;
	assign rdy_o      = rdy_q;
	assign gp_o       = out_q;
	assign intr_req_o = intr_q;

endmodule

// File: hdl/dev_table.sv
// Device table slot. Word 0 takes software reset commands, words 1 and up
// describe each slot of the address map.
`timescale 1ns/1ns
`include "soc_config.svh"

module dev_table import soc_pkg::*; (
	input  logic                        clk100mhz,
	input  logic                        sys_rst_i,
	input  pi1_op_t                     op_i,
	input  logic [`SLOT_ADDR_BITSZ-1:0] addr_i,
	input  logic [`ARCH_BITSZ-1:0]      data_i,
	input  logic [`SEL_BITSZ-1:0]       sel_i,
	output logic [`ARCH_BITSZ-1:0]      data_o,
	output logic                        rdy_o,
	output logic                        warm_rst_o,
	output logic                        pwroff_o
);

	localparam logic [`SLOT_ADDR_BITSZ-1:0] last_entry = `DEV_COUNT;

	logic                   req_w;
	logic                   wr_w;
	logic [`ARCH_BITSZ-1:0] rd_w;
	logic                   rdy_q;
	logic [1:0]             cmd_q;
	logic [`ARCH_BITSZ-1:0] data_q;

	function automatic logic [`ARCH_BITSZ-1:0] slot_entry(input slot_idx_t slot);
		devtbl_entry_u e;
		e.raw = '0;
		case (slot)
			`SLOT_DEVTBL: begin
				e.f.useintr = `DEVTBL_USEINTR;
				e.f.id      = `DEVTBL_ID;
				e.f.mapsz   = 24'(`SLOT_WORDS);
			end
			`SLOT_GPIO: begin
				e.f.useintr = `GPIO_USEINTR;
				e.f.id      = `GPIO_ID;
				e.f.mapsz   = 24'(`SLOT_WORDS);
			end
			`SLOT_INTCTRL: begin
				e.f.useintr = `INTCTRL_USEINTR;
				e.f.id      = `INTCTRL_ID;
				e.f.mapsz   = 24'(`SLOT_WORDS);
			end
			default: begin
				e.f.useintr = `INVALID_USEINTR;
				e.f.id      = `INVALID_ID;
				e.f.mapsz   = 24'(`INVALID_MAPSZ);
			end
		endcase
		return e.raw;
	endfunction

	assign req_w = (op_i != NONE) && !rdy_q;
	assign wr_w  = req_w && ((op_i == WRITE) || (op_i == SWAP));

	always_comb begin
		if (addr_i == '0) begin
			rd_w = {{(`ARCH_BITSZ-2){1'b0}}, cmd_q};
		end else if (addr_i <= last_entry) begin
			rd_w = slot_entry(slot_idx_t'(addr_i - 1'b1));
		end else begin
			rd_w = '0;
		end
	end

	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i) begin
			rdy_q <= 1'b0;
			cmd_q <= 2'b00; // The command is done once the reset takes hold.
		end else begin
			rdy_q <= req_w;
			if (wr_w && (addr_i == '0) && sel_i[0]) begin
				cmd_q <= data_i[1:0];
			end
		end
	end

	always_ff @(posedge clk100mhz) begin
		if (req_w) begin
			data_q <= rd_w;
		end
	end

	assign data_o     = data_q;
	assign rdy_o      = rdy_q;
	assign warm_rst_o = cmd_q[1]; // Cold reset runs as a warm reset.
	assign pwroff_o   = cmd_q[0] && !cmd_q[1];

endmodule

// File: hdl/pi1_router.sv
// PI1 address router. Steers the single master onto the device slots and
// answers unmapped addresses itself, raising an interrupt for each such access.
`timescale 1ns/1ns
`include "soc_config.svh"

module pi1_router import soc_pkg::*; (
	input  logic                        clk100mhz,
	input  logic                        sys_rst_i,
	input  pi1_op_t                     m_op_i,
	input  logic [`ADDR_BITSZ-1:0]      m_addr_i,
	input  logic [`ARCH_BITSZ-1:0]      m_data_i,
	input  logic [`SEL_BITSZ-1:0]       m_sel_i,
	output logic [`ARCH_BITSZ-1:0]      m_data_o,
	output logic                        m_rdy_o,
	output pi1_op_t                     s_op_o [`DEV_COUNT-1],
	output logic [`SLOT_ADDR_BITSZ-1:0] s_addr_o,
	output logic [`ARCH_BITSZ-1:0]      s_data_o,
	output logic [`SEL_BITSZ-1:0]       s_sel_o,
	input  logic [`ARCH_BITSZ-1:0]      s_data_i [`DEV_COUNT-1],
	input  logic [`DEV_COUNT-2:0]       s_rdy_i,
	output logic                        errintr_o,
	input  logic                        errintr_ack_i
);

	localparam logic [`ADDR_BITSZ-1:0] slot_base [`DEV_COUNT-1] = '{
		`DEVTBL_BASE,
		`GPIO_BASE,
		`INTCTRL_BASE
	};

	slot_idx_t sel_w;
	logic      inval_w;
	logic      errintr_q;

	// ********************
	// Decode and forwarding.
	always_comb begin
		sel_w = `SLOT_INVALID;
		for (int i = 0; i < `DEV_COUNT-1; i++) begin
			if (m_addr_i[`ADDR_BITSZ-1:`SLOT_ADDR_BITSZ] ==
					slot_base[i][`ADDR_BITSZ-1:`SLOT_ADDR_BITSZ]) begin
				sel_w = slot_idx_t'(i);
			end
		end
	end

	always_comb begin
		for (int i = 0; i < `DEV_COUNT-1; i++) begin
			s_op_o[i] = (sel_w == slot_idx_t'(i)) ? m_op_i : NONE;
		end
	end

	assign s_addr_o = m_addr_i[`SLOT_ADDR_BITSZ-1:0]; // Offset within the slot.
	assign s_data_o = m_data_i;
	assign s_sel_o  = m_sel_i;

	assign inval_w = (sel_w == `SLOT_INVALID) && (m_op_i != NONE);

	always_comb begin
		if (sel_w == `SLOT_INVALID) begin
			m_data_o = '0;
			m_rdy_o  = inval_w; // The invalid device answers at once.
		end else begin
			m_data_o = s_data_i[sel_w];
			m_rdy_o  = s_rdy_i[sel_w];
		end
	end

	// ********************
	// Invalid access interrupt.
	// Accesses made while ack is still high fold into the request already delivered.
	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i) begin
			errintr_q <= 1'b0;
		end else if (errintr_ack_i) begin
			errintr_q <= 1'b0;
		end else if (inval_w) begin
			errintr_q <= 1'b1;
		end
	end

	assign errintr_o = errintr_q;

endmodule

// File: hdl/soc_reset_ctrl.sv
// Reset controller. Stretches board and warm resets into the system reset
// and keeps a power-off latched until the next board reset.
`timescale 1ns/1ns
`include "soc_config.svh"

module soc_reset_ctrl (
	input  logic clk100mhz,
	input  logic rst_p,
	input  logic warm_rst_i,
	input  logic pwroff_i,
	output logic sys_rst_o
);

	logic [`RST_CNTR_BITSZ-1:0] rst_cntr;
	logic                       pwroff_q;

	always_ff @(posedge clk100mhz) begin
		if (rst_p || warm_rst_i) begin
			rst_cntr <= '1; // Hold-off restarts from full count.
		end else if (rst_cntr != '0) begin
			rst_cntr <= rst_cntr - 1'b1;
		end
	end

	always_ff @(posedge clk100mhz) begin
		if (rst_p) begin
			pwroff_q <= 1'b0;
		end else if (pwroff_i) begin
			pwroff_q <= 1'b1; // Only the board reset brings the system back.
		end
	end

	assign sys_rst_o = rst_p || (rst_cntr != '0) || pwroff_q;

endmodule

// File: hdl/soc_pkg.sv
// Bus operation, slot index and device table entry types.
// Imported by the fabric modules and the testbench.
`include "soc_config.svh"

package soc_pkg;

	typedef enum logic [1:0] {
		NONE  = 2'b00,
		WRITE = 2'b01,
		READ  = 2'b10,
		SWAP  = 2'b11 // Read and write in one transfer.
	} pi1_op_t;

	typedef logic [1:0] slot_idx_t;

	typedef struct packed {
		logic        useintr;
		logic [6:0]  id;
		logic [23:0] mapsz;
	} devtbl_fields_t;

	// One table word, seen either as it travels on the bus or as its fields.
	typedef union packed {
		logic [`ARCH_BITSZ-1:0] raw;
		devtbl_fields_t         f;
	} devtbl_entry_u;

endpackage

// File: hdl/soc_config.svh
// Widths, address map, device ids and counter sizes of the peripheral fabric.
// Included by the package, the RTL modules and the testbench.
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

`define ARCH_BITSZ      32
`define ADDR_BITSZ      30
`define SEL_BITSZ       4
`define GPIO_COUNT      8

// ********************
// Address map. Slots sit in this order, everything else is the invalid device.
`define SLOT_WORDS      16
`define SLOT_ADDR_BITSZ 4
`define DEVTBL_BASE     30'd0
`define GPIO_BASE       30'd16
`define INTCTRL_BASE    30'd32
`define INVALID_MAPSZ   1024
`define DEV_COUNT       4
`define SLOT_DEVTBL     2'd0
`define SLOT_GPIO       2'd1
`define SLOT_INTCTRL    2'd2
`define SLOT_INVALID    2'd3

// ********************
// Device ids and interrupt use per slot.
`define DEVTBL_ID       7'd7
`define GPIO_ID         7'd6
`define INTCTRL_ID      7'd3
`define INVALID_ID      7'd0
`define DEVTBL_USEINTR  1'b0
`define GPIO_USEINTR    1'b1
`define INTCTRL_USEINTR 1'b0
`define INVALID_USEINTR 1'b0

`define RST_CNTR_BITSZ  4
`define INT_SRC_COUNT   2
`define INT_SRC_GPIO    0
`define INT_SRC_INVALID 1

`endif
